// ==== flist.f ====
verilog/hisPkg.sv
verilog/hisBinDecoder.sv
verilog/hisCountRam.sv
verilog/hisBuilderFsm.sv
verilog/hisPeakFinder.sv
verilog/hisTop.sv
verif/hisTbChecker.sv
verif/hisTop_chk.sv
verif/hisTb.sv

// ==== verif/hisTb.sv ====
module hisTb import hisPkg::*; ();

    localparam logic [31:0] SEED = 32'h499d_d689;
    // events over all tests, test 5 sends two frames
    localparam int EVENT_TOTAL = 1 + 200 + 60 + 300 + 40 + 13 + 100;
    localparam int FRAME_TOTAL = 7;
    localparam int TIMEOUT_CYCLES =
        2 * (RAM_DEPTH + 10 * EVENT_TOTAL + 30 * PIXEL_NUM * FRAME_TOTAL);

    logic        clk = 1'b0;
    logic        res;
    logic        evReq;
    logic        evAck;
    hisEventT    evData;
    logic        pkReq;
    logic        pkAck;
    hisPeakT     pkData;
    countT       dropCount;
    // separate streams for events and acks
    logic [31:0] evRng = SEED;
    logic [31:0] ackRng = SEED ^ 32'h5a5a_0000;
    logic        slowAck = 1'b0;
    int          peaksDone = 0;
    int          recordTarget = 0;
    int          cycles = 0;

    hisTop hisTop_i (
        .clk, .res, .evReq, .evAck, .evData, .pkReq, .pkAck, .pkData, .dropCount
    );

    hisTbChecker tbChecker (
        .clk, .res, .evReq, .evAck, .evData, .pkReq, .pkAck, .pkData, .dropCount
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // one four-phase transfer on the input link
    task automatic sendEvent(input int pix, input int ts, input logic last, input int gap);
        repeat (gap) @(negedge clk);
        evData.pixel = pixelT'(pix);
        evData.ts    = tsT'(ts);
        evData.last  = last;
        evReq = 1'b1;
        @(negedge clk);
        while (!evAck) @(negedge clk);
        evReq = 1'b0;
        // data stays put until the next request
        while (evAck) @(negedge clk);
    endtask

    // all peak records of one frame acknowledged
    task automatic waitFrame();
        recordTarget += PIXEL_NUM;
        while (peaksDone < recordTarget) @(negedge clk);
    endtask

    // pkAck responder, random delay per record
    initial begin
        int delay;
        pkAck = 1'b0;
        forever begin
            @(negedge clk);
            if (pkReq === 1'b1) begin
                ackRng = xorshift32(ackRng);
                delay = slowAck ? 4 + int'(ackRng[2:0]) : int'(ackRng[1:0]);
                repeat (delay) @(negedge clk);
                pkAck = 1'b1;
                @(negedge clk);
                while (pkReq) @(negedge clk);
                pkAck = 1'b0;
                peaksDone++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped: no progress after %0d cycles, %0d peak records seen",
                cycles, peaksDone);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int pix;
        int errors;
        res    = 1'b0;
        evReq  = 1'b0;
        evData = '0;
        repeat (2) @(negedge clk);
        res = 1'b1;

        // reset state, then one event while the sweep still runs
        tbChecker.checkIdle();
        sendEvent(4, 8'ha7, 1'b1, 0);
        waitFrame();
        tbChecker.finishTest("reset and clear");

        for (int i = 0; i < 200; i++) begin
            evRng = xorshift32(evRng);
            sendEvent(evRng[7:0] % PIXEL_NUM, evRng[15:8], i == 199, 0);
        end
        waitFrame();
        tbChecker.finishTest("random frame");

        // every fourth pixel out of range, frame closes on pixel 7
        for (int i = 0; i < 60; i++) begin
            evRng = xorshift32(evRng);
            pix = (i % 4 == 0) ? 6 + int'(evRng[16]) : int'(evRng[18:16]);
            if (i == 59) begin
                pix = 7;
            end
            sendEvent(pix, evRng[15:8], i == 59, 0);
        end
        waitFrame();
        tbChecker.finishTest("range check");

        // pixel 1 bin 5 runs past the top count
        for (int i = 0; i < 300; i++) begin
            evRng = xorshift32(evRng);
            sendEvent(1, {4'h5, evRng[3:0]}, i == 299, 0);
        end
        waitFrame();
        tbChecker.finishTest("saturation");

        for (int i = 0; i < 40; i++) begin
            evRng = xorshift32(evRng);
            sendEvent(evRng[7:0] % PIXEL_NUM, evRng[15:8], i == 39, 0);
        end
        waitFrame();
        // bins 3 and 9 of pixel 2 tie at five
        for (int i = 0; i < 10; i++) begin
            sendEvent(2, (i % 2 == 0) ? 8'h3c : 8'h91, 1'b0, 0);
        end
        sendEvent(0, 8'h70, 1'b0, 0);
        sendEvent(0, 8'h7f, 1'b0, 0);
        sendEvent(5, 8'h12, 1'b1, 0);
        waitFrame();
        tbChecker.finishTest("clearing between frames");

        slowAck = 1'b1;
        for (int i = 0; i < 100; i++) begin
            evRng = xorshift32(evRng);
            sendEvent(evRng[7:0] % PIXEL_NUM, evRng[15:8], i == 99, int'(evRng[25:24]));
        end
        waitFrame();
        tbChecker.finishTest("back-pressure");

        errors = tbChecker.errorCount + hisTop_i.hisTopChk_i.assertFails;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, cycles %0d",
            tbChecker.testNum, tbChecker.testsPassed, tbChecker.testsFailed, errors, cycles);
        if (tbChecker.testsFailed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/hisTbChecker.sv ====
module hisTbChecker import hisPkg::*; (
    input logic     clk,
    input logic     res,
    input logic     evReq,
    input logic     evAck,
    input hisEventT evData,
    input logic     pkReq,
    input logic     pkAck,
    input hisPeakT  pkData,
    input countT    dropCount
);

    // reference histogram of the current frame
    int       refHist [PIXEL_NUM][BIN_NUM];
    int       refDrop = 0;
    hisEventT pending;
    logic     ackSeen = 1'b0;
    logic     pkSeen = 1'b0;
    int       expPix = 0;
    int       errorCount = 0;
    int       testErrors = 0;
    int       testsPassed = 0;
    int       testsFailed = 0;
    int       testNum = 0;
    int       framesInTest = 0;
    int       recordsInTest = 0;

    // expected peak of one pixel, ties keep the lowest bin
    function automatic hisPeakT refPeak(input int pix);
        hisPeakT p;
        int      best;
        best    = 0;
        p.pixel = pixelT'(pix);
        // empty pixel gives bin 0 count 0
        p.bin   = '0;
        for (int b = 0; b < BIN_NUM; b++) begin
            if (refHist[pix][b] > best) begin
                best  = refHist[pix][b];
                p.bin = binT'(b);
            end
        end
        p.count = countT'(best);
        return p;
    endfunction

    function automatic void addEvent(input hisEventT ev);
        int bin;
        // upper four timestamp bits
        bin = int'(ev.ts >> (TS_W - BIN_W));
        if (ev.last) begin
            framesInTest++;
        end
        if (ev.pixel < PIXEL_NUM) begin
            if (refHist[ev.pixel][bin] < COUNT_MAX) begin
                refHist[ev.pixel][bin]++;
            end
        end else if (refDrop < COUNT_MAX) begin
            refDrop++;
        end
    endfunction

    task automatic valueError(input string name, input logic [31:0] got, input int want);
        $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, want);
        errorCount++;
        testErrors++;
    endtask

    task automatic reportFailure(input string msg);
        $display("failure at %0t: %s", $time, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic checkIdle();
        if (evAck !== 1'b0) valueError("evAck", evAck, 0);
        if (pkReq !== 1'b0) valueError("pkReq", pkReq, 0);
    endtask

    task automatic finishTest(input string name);
        testNum++;
        if (recordsInTest != framesInTest * PIXEL_NUM || expPix != 0) begin
            reportFailure($sformatf("%0d peak records arrived for %0d frames",
                recordsInTest, framesInTest));
        end
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %0d %s: passed, %0d records", testNum, name, recordsInTest);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testNum, name, testErrors);
        end
        testErrors    = 0;
        framesInTest  = 0;
        recordsInTest = 0;
    endtask

    // request data kept until ack rises
    always @(posedge clk) begin
        if (res) begin
            if (evReq && !evAck) begin
                pending = evData;
            end
            if (evAck && !ackSeen) begin
                addEvent(pending);
            end
            ackSeen = evAck;
        end
    end

    // compare each peak record in the cycle its handshake completes
    always @(posedge clk) begin
        hisPeakT want;
        if (res) begin
            if (pkReq && pkAck && !pkSeen) begin
                want = refPeak(expPix);
                if (pkData.pixel !== want.pixel) begin
                    valueError("pkData.pixel", pkData.pixel, want.pixel);
                end
                if (pkData.bin !== want.bin) begin
                    valueError("pkData.bin", pkData.bin, want.bin);
                end
                if (pkData.count !== want.count) begin
                    valueError("pkData.count", pkData.count, want.count);
                end
                recordsInTest++;
                if (expPix == PIXEL_NUM - 1) begin
                    expPix = 0;
                    if (dropCount !== countT'(refDrop)) begin
                        valueError("dropCount", dropCount, refDrop);
                    end
                    // frame read out, DUT memory is zero again
                    foreach (refHist[p, b]) begin
                        refHist[p][b] = 0;
                    end
                end else begin
                    expPix++;
                end
            end
            pkSeen = pkReq && pkAck;
        end
    end

endmodule

// ==== verif/hisTop_chk.sv ====
module hisTopChk import hisPkg::*; (
    input logic     clk,
    input logic     res,
    input logic     evReq,
    input logic     evAck,
    input hisEventT evData,
    input logic     pkReq,
    input logic     pkAck,
    input hisPeakT  pkData,
    input logic     pWe,
    input logic     scanOwn,
    input logic     scanStart,
    input logic     scanDone
);

    // failed assertions, summed into the closing line
    int assertFails = 0;

    // ack only answers a pending request
    evAckNeedsReq: assert property (@(posedge clk) disable iff (!res)
        $rose(evAck) |-> $past(evReq))
        else begin
            $error("evAck rose without evReq");
            assertFails++;
        end

    evDataStable: assert property (@(posedge clk) disable iff (!res)
        evReq && $past(evReq) |-> $stable(evData))
        else begin
            $error("evData changed while evReq was high");
            assertFails++;
        end

    pkDataStable: assert property (@(posedge clk) disable iff (!res)
        pkReq && $past(pkReq) |-> $stable(pkData))
        else begin
            $error("pkData changed while pkReq was high");
            assertFails++;
        end

    // no withdrawn request
    pkReqHeld: assert property (@(posedge clk) disable iff (!res)
        pkReq && !pkAck |=> pkReq)
        else begin
            $error("pkReq fell before pkAck");
            assertFails++;
        end

    // start only while the peak finder is quiet, done only inside a scan
    scanStartOutside: assert property (@(posedge clk) disable iff (!res)
        scanStart |-> !pkReq && !pWe)
        else begin
            $error("scanStart during an active scan");
            assertFails++;
        end

    scanDoneInside: assert property (@(posedge clk) disable iff (!res)
        scanDone |-> scanOwn)
        else begin
            $error("scanDone outside a scan");
            assertFails++;
        end

endmodule

bind hisTop hisTopChk hisTopChk_i (
    .clk(clk),
    .res(res),
    .evReq(evReq),
    .evAck(evAck),
    .evData(evData),
    .pkReq(pkReq),
    .pkAck(pkAck),
    .pkData(pkData),
    .pWe(pWe),
    .scanOwn(scanOwn),
    .scanStart(scanStart),
    .scanDone(scanDone)
);

// ==== verilog/hisBinDecoder.sv ====
module hisBinDecoder import hisPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     evReq,
    output logic     evAck,
    input  hisEventT evData,
    output logic     binReq,
    input  logic     binAck,
    output hisBinT   binData,
    output countT    dropCount
);

    logic inRange;
    logic free;
    logic take;
    binT  evBin;

    // pixel inside the array
    assign inRange = (evData.pixel < PIXEL_NUM);
    // bin is the top of the timestamp
    assign evBin = evData.ts[TS_W-1 -: BIN_W];
    // both links idle, builder released its ack
    assign free = !evAck && !binReq && !binAck;
    assign take = free && evReq;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evAck     <= 1'b0;
            binReq    <= 1'b0;
            dropCount <= '0;
        end else begin
            if (take) begin
                // last events always go on so the frame can close
                if (inRange || evData.last) begin
                    binReq <= 1'b1;
                end else begin
                    evAck <= 1'b1;
                end
                // every out of range event is a drop
                if (!inRange && dropCount != countT'(COUNT_MAX)) begin
                    dropCount <= dropCount + 1'b1;
                end
            end
            // builder took it, release inner req and ack the source
            if (binReq && binAck) begin
                binReq <= 1'b0;
                evAck  <= 1'b1;
            end
            // source dropped req
            if (evAck && !evReq) begin
                evAck <= 1'b0;
            end
        end
    end

    // record held while binReq is up
    always_ff @(posedge clk) begin
        if (take) begin
            binData.addr    <= binAddr(evData.pixel, evBin);
            binData.countEn <= inRange;
            binData.last    <= evData.last;
        end
    end

endmodule

// ==== verilog/hisBuilderFsm.sv ====
module hisBuilderFsm import hisPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    binReq,
    output logic    binAck,
    input  hisBinT  binData,
    output logic    bWe,
    output ramAddrT bWaddr,
    output countT   bWdata,
    output ramAddrT bRaddr,
    input  countT   rdata,
    output logic    scanOwn,
    output logic    scanStart,
    input  logic    scanDone
);

    builderStateT state;
    builderStateT nextState;
    ramAddrT      clrAddr;
    logic         clrEnd;
    countT        newCount;

    // sweep reaches the top word
    assign clrEnd = (clrAddr == ramAddrT'(RAM_DEPTH - 1));

    always_comb begin
        nextState = state;
        case (state)
            BLD_CLEAR: begin
                if (clrEnd) begin
                    nextState = BLD_IDLE;
                end
            end
            BLD_IDLE: begin
                if (binReq) begin
                    nextState = BLD_READ;
                end
            end
            // address out, data registered in the RAM
            BLD_READ: nextState = BLD_WAIT;
            // increment captured
            BLD_WAIT: nextState = BLD_WRITE;
            BLD_WRITE: nextState = BLD_ACK;
            BLD_ACK: begin
                // frame end goes straight to the scan
                if (binData.last) begin
                    nextState = BLD_SCAN;
                end else if (!binReq) begin
                    nextState = BLD_IDLE;
                end
            end
            // decoder dropped binReq long before the scan ends
            BLD_SCAN: begin
                if (scanDone) begin
                    nextState = BLD_IDLE;
                end
            end
            default: nextState = BLD_CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= BLD_CLEAR;
            clrAddr <= '0;
        end else begin
            state <= nextState;
            if (state == BLD_CLEAR) begin
                clrAddr <= clrAddr + 1'b1;
            end
        end
    end

    // saturating increment of the bin just read
    always_ff @(posedge clk) begin
        if (state == BLD_WAIT) begin
            newCount <= (rdata == countT'(COUNT_MAX)) ? rdata : rdata + 1'b1;
        end
    end

    // write port shared by the clear sweep and the event update
    assign bWe    = (state == BLD_CLEAR) || (state == BLD_WRITE && binData.countEn);
    assign bWaddr = (state == BLD_CLEAR) ? clrAddr : binData.addr;
    assign bWdata = (state == BLD_CLEAR) ? '0 : newCount;
    // record is stable all through the event
    assign bRaddr = binData.addr;

    // ack held over the whole scan on a last event
    assign binAck    = (state == BLD_ACK) || (state == BLD_SCAN);
    assign scanOwn   = (state == BLD_SCAN);
    assign scanStart = (state == BLD_ACK) && binData.last;

endmodule

// ==== verilog/hisCountRam.sv ====
module hisCountRam import hisPkg::*; (
    input  logic    clk,
    input  logic    scanOwn,
    input  logic    bWe,
    input  ramAddrT bWaddr,
    input  countT   bWdata,
    input  ramAddrT bRaddr,
    input  logic    pWe,
    input  ramAddrT pWaddr,
    input  ramAddrT pRaddr,
    output countT   rdata
);

    countT   mem [RAM_DEPTH];
    logic    we;
    ramAddrT waddr;
    countT   wdata;
    ramAddrT raddr;

    // port owner select
    always_comb begin
        we    = scanOwn ? pWe : bWe;
        waddr = scanOwn ? pWaddr : bWaddr;
        // peak finder only ever clears
        wdata = scanOwn ? '0 : bWdata;
        raddr = scanOwn ? pRaddr : bRaddr;
    end

    // read returns old data on a same address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// ==== verilog/hisPeakFinder.sv ====
module hisPeakFinder import hisPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    scanStart,
    output logic    scanDone,
    output logic    pWe,
    output ramAddrT pWaddr,
    output ramAddrT pRaddr,
    input  countT   rdata,
    output logic    pkReq,
    input  logic    pkAck,
    output hisPeakT pkData
);

    peakStateT state;
    pixelT     pix;
    binT       rdBin;
    binT       cmpBin;
    logic      cmpValid;
    binT       bestBin;
    countT     bestCount;
    logic      lastPix;

    assign lastPix = (pix == pixelT'(PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= PK_IDLE;
            pix      <= '0;
            rdBin    <= '0;
            cmpValid <= 1'b0;
        end else begin
            // rdata shows up one cycle after the read
            cmpValid <= (state == PK_READ);
            case (state)
                PK_IDLE: begin
                    if (scanStart) begin
                        pix   <= '0;
                        rdBin <= '0;
                        state <= PK_READ;
                    end
                end
                // one bin per cycle
                PK_READ: begin
                    rdBin <= rdBin + 1'b1;
                    if (rdBin == binT'(BIN_NUM - 1)) begin
                        state <= PK_SCAN;
                    end
                end
                // last bin compared here
                PK_SCAN: state <= PK_SEND;
                PK_SEND: begin
                    if (pkAck) begin
                        state <= PK_RELEASE;
                    end
                end
                PK_RELEASE: begin
                    if (!pkAck) begin
                        if (lastPix) begin
                            state <= PK_IDLE;
                        end else begin
                            pix   <= pix + 1'b1;
                            rdBin <= '0;
                            state <= PK_READ;
                        end
                    end
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    // peak track, bin 0 seeds it and ties keep the lower bin
    always_ff @(posedge clk) begin
        cmpBin <= rdBin;
        if (cmpValid && (cmpBin == '0 || rdata > bestCount)) begin
            bestCount <= rdata;
            bestBin   <= cmpBin;
        end
    end

    assign pRaddr = binAddr(pix, rdBin);
    // clear behind the read
    assign pWe    = cmpValid;
    assign pWaddr = binAddr(pix, cmpBin);

    assign pkReq         = (state == PK_SEND);
    assign pkData.pixel  = pix;
    assign pkData.bin    = bestBin;
    assign pkData.count  = bestCount;
    // handshake of the final pixel closed
    assign scanDone = (state == PK_RELEASE) && !pkAck && lastPix;

endmodule

// ==== verilog/hisPkg.sv ====
package hisPkg;

    // array geometry
    localparam int PIXEL_NUM = 6;
    localparam int BIN_NUM   = 16;
    localparam int RAM_DEPTH = PIXEL_NUM * BIN_NUM;

    // field widths
    localparam int PIXEL_W = 3;
    localparam int BIN_W   = 4;
    localparam int TS_W    = 8;
    localparam int COUNT_W = 8;
    localparam int ADDR_W  = 7;

    // bin counts stop here
    localparam int COUNT_MAX = 255;

    typedef logic [PIXEL_W-1:0] pixelT;
    typedef logic [BIN_W-1:0]   binT;
    typedef logic [TS_W-1:0]    tsT;
    typedef logic [COUNT_W-1:0] countT;
    typedef logic [ADDR_W-1:0]  ramAddrT;

    // one photon event from the array
    typedef struct packed {
        pixelT pixel;
        tsT    ts;
        logic  last;
    } hisEventT;

    // decoded event for the builder
    typedef struct packed {
        ramAddrT addr;
        logic    countEn;
        logic    last;
    } hisBinT;

    // peak record, one per pixel
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } hisPeakT;

    typedef enum logic [2:0] {
        BLD_CLEAR, BLD_IDLE, BLD_READ, BLD_WAIT, BLD_WRITE, BLD_ACK, BLD_SCAN
    } builderStateT;

    typedef enum logic [2:0] {
        PK_IDLE, PK_READ, PK_SCAN, PK_SEND, PK_RELEASE
    } peakStateT;

    // pixel histograms sit back to back in the count memory
    function automatic ramAddrT binAddr(pixelT pix, binT idx);
        return ramAddrT'(pix * BIN_NUM + idx);
    endfunction

endpackage

// ==== verilog/hisTop.sv ====
module hisTop import hisPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     evReq,
    output logic     evAck,
    input  hisEventT evData,
    output logic     pkReq,
    input  logic     pkAck,
    output hisPeakT  pkData,
    output countT    dropCount
);

    // decoder to builder
    logic    binReq;
    logic    binAck;
    hisBinT  binData;

    // builder side of the memory
    logic    bWe;
    ramAddrT bWaddr;
    countT   bWdata;
    ramAddrT bRaddr;

    // peak finder side of the memory
    logic    pWe;
    ramAddrT pWaddr;
    ramAddrT pRaddr;
    countT   rdata;

    // scan hand-off
    logic    scanOwn;
    logic    scanStart;
    logic    scanDone;

    hisBinDecoder hisBinDecoder_i (
        .clk, .res, .evReq, .evAck, .evData,
        .binReq, .binAck, .binData, .dropCount
    );

    hisCountRam hisCountRam_i (
        .clk, .scanOwn, .bWe, .bWaddr, .bWdata, .bRaddr,
        .pWe, .pWaddr, .pRaddr, .rdata
    );

    hisBuilderFsm hisBuilderFsm_i (
        .clk, .res, .binReq, .binAck, .binData,
        .bWe, .bWaddr, .bWdata, .bRaddr, .rdata,
        .scanOwn, .scanStart, .scanDone
    );

    hisPeakFinder hisPeakFinder_i (
        .clk, .res, .scanStart, .scanDone,
        .pWe, .pWaddr, .pRaddr, .rdata,
        .pkReq, .pkAck, .pkData
    );

endmodule
